// File: riscv_lsu_defs.svh
`ifndef RISCV_LSU_DEFS_SVH
`define RISCV_LSU_DEFS_SVH

////////////////////////////////////////
// data path widths
////////////////////////////////////////

`define LSU_WORD_W 32 // data and address bus
`define LSU_BE_W   4  // one enable per byte lane
`define LSU_SIZE_W 2  // access size code

////////////////////////////////////////
// access size codes
////////////////////////////////////////

`define LSU_SIZE_WORD 0
`define LSU_SIZE_HALF 1
`define LSU_SIZE_BYTE 2

// outstanding accesses the memory may hold for us
// one waiting for grant does not count, only granted ones
`define LSU_QUEUE_DEPTH 2

`endif

// File: riscv_lsu_pkg.sv
`include "riscv_lsu_defs.svh"

package riscv_lsu_pkg;

  ////////////////////////////////////////
  // vector types
  ////////////////////////////////////////

  // one data word on the memory bus
  typedef logic [`LSU_WORD_W-1:0] word_t;

  // byte address, same width as data
  typedef logic [`LSU_WORD_W-1:0] addr_t;

  // byte enables, one per lane
  typedef logic [`LSU_BE_W-1:0] be_t;

  // word, half or byte, see defs header for the codes
  typedef logic [`LSU_SIZE_W-1:0] mem_size_t;

  // lane index inside a word
  typedef logic [$clog2(`LSU_BE_W)-1:0] byte_off_t;

  ////////////////////////////////////////
  // controller fsm
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    LSU_IDLE,        // nothing pending, nothing in flight
    LSU_WAIT_GNT,    // request on the bus, grant outstanding
    LSU_WAIT_RVALID  // granted, waiting on response data
  } lsu_state_e;

endpackage

// File: lsu_req_if.sv
`timescale 1ns/10ps

// registered request as seen by the store side
interface lsu_req_if;

  logic                      we;       // store when set
  riscv_lsu_pkg::mem_size_t  size;     // access size code
  logic                      sign_ext; // for loads only
  riscv_lsu_pkg::byte_off_t  byte_off; // low address bits
  riscv_lsu_pkg::word_t      wdata;    // unaligned store data

  // controller owns the request register
  modport ctrl_mp (
    output we,
    output size,
    output sign_ext,
    output byte_off,
    output wdata
  );

  // store aligner only needs placement info
  modport store_mp (
    input we,
    input size,
    input byte_off,
    input wdata
  );

endinterface

// File: lsu_store_align.sv
`timescale 1ns/10ps

`include "riscv_lsu_defs.svh"

module lsu_store_align (
  lsu_req_if.store_mp              req_i,
  output riscv_lsu_pkg::be_t       data_be_o,
  output riscv_lsu_pkg::word_t     data_wdata_o
);

  riscv_lsu_pkg::be_t   be_half;  // two lanes from offset
  riscv_lsu_pkg::be_t   be_byte;  // one lane at offset
  riscv_lsu_pkg::word_t wdata_rep; // replicated store data

  assign be_half = riscv_lsu_pkg::be_t'(2'b11) << req_i.byte_off;
  assign be_byte = riscv_lsu_pkg::be_t'(1'b1) << req_i.byte_off;

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////

  // same rule for loads and stores
  always_comb begin
    case (req_i.size)
      riscv_lsu_pkg::mem_size_t'(`LSU_SIZE_HALF): data_be_o = be_half;
      riscv_lsu_pkg::mem_size_t'(`LSU_SIZE_BYTE): data_be_o = be_byte;
      default:                                    data_be_o = '1; // full word
    endcase
  end

  ////////////////////////////////////////
  // store data
  ////////////////////////////////////////

  // repeat into every lane, memory picks via be
  always_comb begin
    case (req_i.size)
      riscv_lsu_pkg::mem_size_t'(`LSU_SIZE_HALF): begin
        wdata_rep = {2{req_i.wdata[15:0]}};
      end
      riscv_lsu_pkg::mem_size_t'(`LSU_SIZE_BYTE): begin
        wdata_rep = {4{req_i.wdata[7:0]}};
      end
      default: begin
        wdata_rep = req_i.wdata; // word goes as is
      end
    endcase
  end

  // keep bus quiet on loads
  assign data_wdata_o = req_i.we ? wdata_rep : '0;

endmodule

// File: lsu_load_align.sv
`timescale 1ns/10ps

`include "riscv_lsu_defs.svh"

module lsu_load_align (
  // memory response
  input  riscv_lsu_pkg::word_t      data_rdata_i,
  input  logic                      data_rvalid_i,
  input  logic                      data_err_i,

  // head of the in-flight queue
  input  riscv_lsu_pkg::mem_size_t  rsp_size_i,
  input  logic                      rsp_sign_ext_i,
  input  riscv_lsu_pkg::byte_off_t  rsp_byte_off_i,
  input  logic                      rsp_we_i,

  // writeback side
  output logic                      wb_valid_o,
  output riscv_lsu_pkg::word_t      wb_rdata_o,
  output logic                      load_err_o,
  output logic                      store_err_o
);

  riscv_lsu_pkg::word_t rdata_shift; // addressed lane moved to bit 0
  riscv_lsu_pkg::word_t rdata_byte;  // extended byte
  riscv_lsu_pkg::word_t rdata_half;  // extended half
  riscv_lsu_pkg::word_t rdata_ext;   // after size select
  logic                 byte_fill;
  logic                 half_fill;

  ////////////////////////////////////////
  // lane extraction
  ////////////////////////////////////////

  // offset in bytes -> shift in bits
  assign rdata_shift = data_rdata_i >> {rsp_byte_off_i, 3'b000};

  // top bit of the lane or zero
  assign byte_fill = rsp_sign_ext_i & rdata_shift[7];
  assign half_fill = rsp_sign_ext_i & rdata_shift[15];

  assign rdata_byte = {{(`LSU_WORD_W-8){byte_fill}}, rdata_shift[7:0]};
  assign rdata_half = {{(`LSU_WORD_W-16){half_fill}}, rdata_shift[15:0]};

  always_comb begin
    case (rsp_size_i)
      riscv_lsu_pkg::mem_size_t'(`LSU_SIZE_HALF): rdata_ext = rdata_half;
      riscv_lsu_pkg::mem_size_t'(`LSU_SIZE_BYTE): rdata_ext = rdata_byte;
      default:                                    rdata_ext = data_rdata_i;
    endcase
  end

  ////////////////////////////////////////
  // writeback and errors
  ////////////////////////////////////////

  // every rvalid closes one access, no stall here
  assign wb_valid_o = data_rvalid_i;

  // stores return nothing useful
  assign wb_rdata_o = rsp_we_i ? '0 : rdata_ext;

  // err only counts together with rvalid
  assign load_err_o  = data_rvalid_i & data_err_i & ~rsp_we_i;
  assign store_err_o = data_rvalid_i & data_err_i & rsp_we_i;

endmodule

// File: lsu_ctrl.sv
`timescale 1ns/10ps

`include "riscv_lsu_defs.svh"

module lsu_ctrl (
  input  logic                      clk,
  input  logic                      arst_n_i,
  // execute side
  input  logic                      ex_valid_i,
  input  logic                      ex_we_i,
  input  logic                      ex_sign_ext_i,
  input  logic                      ex_useincr_i,     // a+b instead of a
  input  riscv_lsu_pkg::mem_size_t  ex_size_i,
  input  riscv_lsu_pkg::addr_t      ex_operand_a_i,
  input  riscv_lsu_pkg::addr_t      ex_operand_b_i,
  input  riscv_lsu_pkg::word_t      ex_wdata_i,
  output logic                      ex_ready_o,
  // memory request side
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  output riscv_lsu_pkg::addr_t      data_addr_o,
  output logic                      data_we_o,
  lsu_req_if.ctrl_mp                req_o,
  // head of queue, for the load aligner
  output riscv_lsu_pkg::mem_size_t  rsp_size_o,
  output logic                      rsp_sign_ext_o,
  output riscv_lsu_pkg::byte_off_t  rsp_byte_off_o,
  output logic                      rsp_we_o,
  output logic                      busy_o
);

  localparam int PTR_W = $clog2(`LSU_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`LSU_QUEUE_DEPTH + 1);

  riscv_lsu_pkg::lsu_state_e state_q, state_n;
  riscv_lsu_pkg::addr_t      addr_n, addr_q; // formed address
  logic                      accept, push, pop;
  logic [PTR_W-1:0]          wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]          cnt_q;

  // in-flight metadata, one slot per granted access
  riscv_lsu_pkg::mem_size_t  q_size [`LSU_QUEUE_DEPTH];
  logic                      q_sign [`LSU_QUEUE_DEPTH];
  riscv_lsu_pkg::byte_off_t  q_off  [`LSU_QUEUE_DEPTH];
  logic                      q_we   [`LSU_QUEUE_DEPTH];

  assign addr_n = ex_useincr_i ? ex_operand_a_i + ex_operand_b_i : ex_operand_a_i;
  assign accept = ex_valid_i & ex_ready_o;
  assign push   = (state_q == riscv_lsu_pkg::LSU_WAIT_GNT) & data_gnt_i;
  assign pop    = data_rvalid_i & (cnt_q != '0); // one rvalid per grant

  ////////////////////////////////////////
  // request register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q         <= addr_n;
      req_o.we       <= ex_we_i;
      req_o.size     <= ex_size_i;
      req_o.sign_ext <= ex_sign_ext_i;
      req_o.byte_off <= addr_n[$bits(riscv_lsu_pkg::byte_off_t)-1:0];
      req_o.wdata    <= ex_wdata_i;
    end
  end

  assign data_req_o  = (state_q == riscv_lsu_pkg::LSU_WAIT_GNT); // held until gnt
  assign data_addr_o = addr_q;
  assign data_we_o   = req_o.we;

  ////////////////////////////////////////
  // fsm
  ////////////////////////////////////////

  always_comb begin
    state_n = state_q;
    case (state_q)
      riscv_lsu_pkg::LSU_IDLE: begin
        if (accept) state_n = riscv_lsu_pkg::LSU_WAIT_GNT;
      end
      riscv_lsu_pkg::LSU_WAIT_GNT: begin
        if (data_gnt_i) state_n = riscv_lsu_pkg::LSU_WAIT_RVALID;
      end
      riscv_lsu_pkg::LSU_WAIT_RVALID: begin
        if (accept) state_n = riscv_lsu_pkg::LSU_WAIT_GNT;   // second one goes out
        else if (pop && cnt_q == CNT_W'(1)) state_n = riscv_lsu_pkg::LSU_IDLE; // last one back
      end
      default: state_n = riscv_lsu_pkg::LSU_IDLE;
    endcase
  end

  // no new request while one is still on the bus, or the queue is full
  assign ex_ready_o = (state_q == riscv_lsu_pkg::LSU_IDLE) |
                      ((state_q == riscv_lsu_pkg::LSU_WAIT_RVALID) &
                       (cnt_q < CNT_W'(`LSU_QUEUE_DEPTH)));

  assign busy_o = (state_q != riscv_lsu_pkg::LSU_IDLE) | (cnt_q != '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= riscv_lsu_pkg::LSU_IDLE;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      state_q <= state_n;
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(`LSU_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(`LSU_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop)      cnt_q <= cnt_q + 1'b1;
      else if (pop && !push) cnt_q <= cnt_q - 1'b1;
    end
  end

  ////////////////////////////////////////
  // in-flight queue
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      q_size[wr_ptr_q] <= req_o.size;
      q_sign[wr_ptr_q] <= req_o.sign_ext;
      q_off[wr_ptr_q]  <= req_o.byte_off;
      q_we[wr_ptr_q]   <= req_o.we;
    end
  end

  // oldest granted access answers next
  assign rsp_size_o     = q_size[rd_ptr_q];
  assign rsp_sign_ext_o = q_sign[rd_ptr_q];
  assign rsp_byte_off_o = q_off[rd_ptr_q];
  assign rsp_we_o       = q_we[rd_ptr_q];

endmodule

// File: riscv_lsu_top.sv
`timescale 1ns/10ps

module riscv_lsu_top (
  input  logic                      clk,
  input  logic                      arst_n_i,

  // execute side, valid/ready
  input  logic                      ex_valid_i,
  input  logic                      ex_we_i,
  input  logic                      ex_sign_ext_i,
  input  logic                      ex_useincr_i,
  input  riscv_lsu_pkg::mem_size_t  ex_size_i,
  input  riscv_lsu_pkg::addr_t      ex_operand_a_i,
  input  riscv_lsu_pkg::addr_t      ex_operand_b_i,
  input  riscv_lsu_pkg::word_t      ex_wdata_i,
  output logic                      ex_ready_o,

  // data memory, req/gnt/rvalid
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  input  logic                      data_err_i,
  output riscv_lsu_pkg::addr_t      data_addr_o,
  output logic                      data_we_o,
  output riscv_lsu_pkg::be_t        data_be_o,
  output riscv_lsu_pkg::word_t      data_wdata_o,
  input  riscv_lsu_pkg::word_t      data_rdata_i,

  // writeback
  output logic                      wb_valid_o,
  output riscv_lsu_pkg::word_t      wb_rdata_o,
  output logic                      load_err_o,
  output logic                      store_err_o,
  output logic                      busy_o
);

  riscv_lsu_pkg::mem_size_t rsp_size;     // queue head
  logic                     rsp_sign_ext;
  riscv_lsu_pkg::byte_off_t rsp_byte_off;
  logic                     rsp_we;

  lsu_req_if req_if ();

  ////////////////////////////////////////
  // controller
  ////////////////////////////////////////

  lsu_ctrl ctrl_i (
    .clk            ( clk            ),
    .arst_n_i       ( arst_n_i       ),
    .ex_valid_i     ( ex_valid_i     ),
    .ex_we_i        ( ex_we_i        ),
    .ex_sign_ext_i  ( ex_sign_ext_i  ),
    .ex_useincr_i   ( ex_useincr_i   ),
    .ex_size_i      ( ex_size_i      ),
    .ex_operand_a_i ( ex_operand_a_i ),
    .ex_operand_b_i ( ex_operand_b_i ),
    .ex_wdata_i     ( ex_wdata_i     ),
    .ex_ready_o     ( ex_ready_o     ),
    .data_req_o     ( data_req_o     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_rvalid_i  ( data_rvalid_i  ),
    .data_addr_o    ( data_addr_o    ),
    .data_we_o      ( data_we_o      ),
    .req_o          ( req_if.ctrl_mp ),
    .rsp_size_o     ( rsp_size       ),
    .rsp_sign_ext_o ( rsp_sign_ext   ),
    .rsp_byte_off_o ( rsp_byte_off   ),
    .rsp_we_o       ( rsp_we         ),
    .busy_o         ( busy_o         )
  );

  ////////////////////////////////////////
  // aligners
  ////////////////////////////////////////

  lsu_store_align store_align_i (
    .req_i        ( req_if.store_mp ),
    .data_be_o    ( data_be_o       ),
    .data_wdata_o ( data_wdata_o    )
  );

  lsu_load_align load_align_i (
    .data_rdata_i   ( data_rdata_i  ),
    .data_rvalid_i  ( data_rvalid_i ),
    .data_err_i     ( data_err_i    ),
    .rsp_size_i     ( rsp_size      ),
    .rsp_sign_ext_i ( rsp_sign_ext  ),
    .rsp_byte_off_i ( rsp_byte_off  ),
    .rsp_we_i       ( rsp_we        ),
    .wb_valid_o     ( wb_valid_o    ),
    .wb_rdata_o     ( wb_rdata_o    ),
    .load_err_o     ( load_err_o    ),
    .store_err_o    ( store_err_o   )
  );

endmodule

// File: tb_riscv_lsu.sv
`timescale 1ns/10ps

module tb_riscv_lsu;

  localparam int         CLK_PERIOD  = 8;
  localparam int         RST_CYCLES  = 5;
  localparam int         MAX_LINES   = 64;
  localparam logic [7:0] LFSR_SEED   = 8'd63;
  localparam logic [7:0] LFSR_TAPS   = 8'hB8; // x^8+x^6+x^5+x^4+1
  localparam int         WD_PER_LINE = 12;    // cycles allowed per access
  localparam int         WD_MARGIN   = 100;
  localparam int         MAX_INFLIGHT = 2;

  logic clk, arst_n_i;
  logic ex_valid_i, ex_we_i, ex_sign_ext_i, ex_useincr_i, ex_ready_o;
  riscv_lsu_pkg::mem_size_t ex_size_i;
  riscv_lsu_pkg::addr_t     ex_operand_a_i, ex_operand_b_i, data_addr_o;
  riscv_lsu_pkg::word_t     ex_wdata_i, data_wdata_o, data_rdata_i, wb_rdata_o;
  riscv_lsu_pkg::be_t       data_be_o;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_err_i, data_we_o;
  logic wb_valid_o, load_err_o, store_err_o, busy_o;

  // one entry per stimulus line
  logic                     s_we [MAX_LINES];
  riscv_lsu_pkg::mem_size_t s_size [MAX_LINES];
  logic                     s_sign [MAX_LINES];
  logic                     s_incr [MAX_LINES];
  riscv_lsu_pkg::addr_t     s_a [MAX_LINES];
  riscv_lsu_pkg::addr_t     s_b [MAX_LINES];
  riscv_lsu_pkg::word_t     s_wdata [MAX_LINES];
  riscv_lsu_pkg::word_t     s_rdata [MAX_LINES];
  logic                     s_err [MAX_LINES];
  riscv_lsu_pkg::addr_t     s_exp_addr [MAX_LINES];
  riscv_lsu_pkg::be_t       s_exp_be [MAX_LINES];
  riscv_lsu_pkg::word_t     s_exp_wdata [MAX_LINES];
  riscv_lsu_pkg::word_t     s_exp_wb [MAX_LINES];

  int n_lines, val_errs, other_errs;
  int gnt_idx, rsp_idx, rsp_done, outstanding, cyc, last_due, wait_left;
  int due_q [$]; // rvalid cycle per granted access, in order
  int idx_q [$]; // matching stimulus line
  logic [7:0] lfsr_q;
  logic in_req, grant_now;
  riscv_lsu_pkg::addr_t held_addr; // request as first seen on the bus
  riscv_lsu_pkg::be_t   held_be;
  riscv_lsu_pkg::word_t held_wdata;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  riscv_lsu_top DUT (.*);

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // one lfsr step per random bit
  function automatic logic rand_bit();
    lfsr_q = lfsr_step(lfsr_q);
    return lfsr_q[0];
  endfunction

  task automatic check_addr(input string name, input riscv_lsu_pkg::addr_t exp,
                            input riscv_lsu_pkg::addr_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_be(input string name, input riscv_lsu_pkg::be_t exp,
                          input riscv_lsu_pkg::be_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_word(input string name, input riscv_lsu_pkg::word_t exp,
                            input riscv_lsu_pkg::word_t act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      val_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      val_errs++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    other_errs++;
  endtask

  task automatic read_stimulus();
    int fd;
    int rc;
    string text;
    fd = $fopen("lsu_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("the stimulus file lsu_stimulus.txt could not be opened");
      return;
    end
    while (!$feof(fd)) begin
      rc = $fgets(text, fd);
      if (rc > 1 && text.getc(0) != "#" && n_lines < MAX_LINES) begin // skip comments
        rc = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                     s_we[n_lines], s_size[n_lines], s_sign[n_lines], s_incr[n_lines],
                     s_a[n_lines], s_b[n_lines], s_wdata[n_lines], s_rdata[n_lines],
                     s_err[n_lines], s_exp_addr[n_lines], s_exp_be[n_lines],
                     s_exp_wdata[n_lines], s_exp_wb[n_lines]);
        if (rc == 13) n_lines++;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  always begin : mem_model
    int due;
    @(negedge clk);
    grant_now = 1'b0;
    if (arst_n_i) begin
      // granted and not yet answered, same count as the dut queue here
      if (outstanding >= MAX_INFLIGHT) begin
        check_flag("ex_ready_o with two in flight", 1'b0, ex_ready_o);
      end
      if (data_rvalid_i) begin // response returned last edge
        check_flag("wb_valid_o", 1'b1, wb_valid_o);
        check_word("wb_rdata_o", s_exp_wb[rsp_idx], wb_rdata_o);
        check_flag("load_err_o", s_err[rsp_idx] & ~s_we[rsp_idx], load_err_o);
        check_flag("store_err_o", s_err[rsp_idx] & s_we[rsp_idx], store_err_o);
        rsp_done++;
        outstanding--;
      end else if (wb_valid_o) begin
        report_failure("wb_valid_o went high with no access outstanding");
      end
      if (data_req_o) begin
        if (!in_req && gnt_idx >= n_lines) begin
          report_failure("the DUT issued more memory requests than the stimulus holds");
        end else if (!in_req) begin
          in_req     = 1'b1;
          held_addr  = data_addr_o;
          held_be    = data_be_o;
          held_wdata = data_wdata_o;
          check_addr("data_addr_o", s_exp_addr[gnt_idx], data_addr_o);
          check_flag("data_we_o", s_we[gnt_idx], data_we_o);
          check_be("data_be_o", s_exp_be[gnt_idx], data_be_o);
          if (s_we[gnt_idx]) check_word("data_wdata_o", s_exp_wdata[gnt_idx], data_wdata_o);
        end else begin
          // grant withheld, bus must hold still
          check_addr("data_addr_o held", held_addr, data_addr_o);
          check_be("data_be_o held", held_be, data_be_o);
          check_word("data_wdata_o held", held_wdata, data_wdata_o);
          check_flag("ex_ready_o while waiting for grant", 1'b0, ex_ready_o);
        end
        if (data_gnt_i) begin // dut takes the grant at the next edge
          in_req = 1'b0;
          due = cyc + 2 + int'(rand_bit()); // rvalid 1 or 2 cycles after grant
          if (due <= last_due) due = last_due + 1; // in order, one per cycle
          last_due = due;
          due_q.push_back(due);
          idx_q.push_back(gnt_idx);
          gnt_idx++;
          outstanding++;
          wait_left = 2 * int'(rand_bit()) + int'(rand_bit()); // next request, 0..3 cycles
        end else if (wait_left > 0) begin
          wait_left--;
        end
      end else if (in_req) begin
        report_failure("data_req_o dropped before the grant");
        in_req = 1'b0;
      end
      grant_now = (wait_left == 0); // zero wait means gnt is already up
      if (outstanding > MAX_INFLIGHT) report_failure("more than two grants are outstanding");
    end
    @(posedge clk);
    cyc++;
    data_gnt_i <= grant_now;
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      rsp_idx = idx_q.pop_front();
      void'(due_q.pop_front());
      data_rvalid_i <= 1'b1;
      data_rdata_i  <= s_rdata[rsp_idx];
      data_err_i    <= s_err[rsp_idx];
    end else begin
      data_rvalid_i <= 1'b0;
      data_rdata_i  <= '0;
      data_err_i    <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // stimulus and end of run
  ////////////////////////////////////////

  initial begin : main
    int i;
    arst_n_i = 1'b0;
    ex_valid_i = 1'b0;
    ex_we_i = 1'b0;
    ex_sign_ext_i = 1'b0;
    ex_useincr_i = 1'b0;
    ex_size_i = '0;
    ex_operand_a_i = '0;
    ex_operand_b_i = '0;
    ex_wdata_i = '0;
    data_gnt_i = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i = 1'b0;
    data_rdata_i = '0;
    lfsr_q = LFSR_SEED;
    in_req = 1'b0;
    last_due = 0;
    wait_left = 2 * int'(rand_bit()) + int'(rand_bit()); // first request
    read_stimulus();
    if (n_lines == 0) report_failure("the stimulus file holds no access");

    fork
      begin : watchdog
        repeat (n_lines * WD_PER_LINE + WD_MARGIN + RST_CYCLES) @(posedge clk);
        report_failure("watchdog expired before all responses came back");
        $display("%0d of %0d responses missing", n_lines - rsp_done, n_lines);
        $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
        $display("RESULT: FAIL");
        $finish;
      end
    join_none

    repeat (RST_CYCLES) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    check_flag("ex_ready_o after reset", 1'b1, ex_ready_o);
    check_flag("data_req_o after reset", 1'b0, data_req_o);
    check_flag("wb_valid_o after reset", 1'b0, wb_valid_o);
    check_flag("load_err_o after reset", 1'b0, load_err_o);
    check_flag("store_err_o after reset", 1'b0, store_err_o);
    check_flag("busy_o after reset", 1'b0, busy_o);

    @(posedge clk);
    for (i = 0; i < n_lines; i++) begin
      ex_valid_i     <= 1'b1;
      ex_we_i        <= s_we[i];
      ex_size_i      <= s_size[i];
      ex_sign_ext_i  <= s_sign[i];
      ex_useincr_i   <= s_incr[i];
      ex_operand_a_i <= s_a[i];
      ex_operand_b_i <= s_b[i];
      ex_wdata_i     <= s_wdata[i];
      do @(negedge clk); while (!ex_ready_o);
      @(posedge clk); // accepted on this edge
    end
    ex_valid_i <= 1'b0;

    wait (rsp_done == n_lines);
    repeat (4) @(negedge clk);
    check_flag("busy_o when drained", 1'b0, busy_o);
    if (gnt_idx != n_lines) report_failure("the number of grants differs from the stimulus");
    $display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: lsu_stimulus.txt
# we size sign incr op_a op_b wdata | mem rdata err | exp addr be wdata wb_rdata
# size 0 word, 1 half, 2 byte; all fields hex
1 0 0 0 00001000 00000000 DEADBEEF 00000000 0 00001000 f DEADBEEF 00000000
1 0 0 1 00001000 00000010 12345678 00000000 0 00001010 f 12345678 00000000
1 1 0 0 00002000 00000000 0000ABCD 00000000 0 00002000 3 ABCDABCD 00000000
1 1 0 1 00002000 00000008 11117777 00000000 0 00002008 3 77777777 00000000
1 2 0 0 00003000 00000000 000000A5 00000000 0 00003000 1 A5A5A5A5 00000000
1 2 0 0 00003007 00000000 FFFFFF3C 00000000 0 00003007 8 3C3C3C3C 00000000
1 2 0 1 00003000 00000007 0000005A 00000000 0 00003007 8 5A5A5A5A 00000000
0 0 0 0 00004000 00000000 00000000 CAFEF00D 0 00004000 f 00000000 CAFEF00D
0 0 0 1 00004000 00000004 00000000 01234567 0 00004004 f 00000000 01234567
0 1 1 0 00005000 00000000 00000000 1234F00D 0 00005000 3 00000000 FFFFF00D
0 1 0 0 00005000 00000000 00000000 1234F00D 0 00005000 3 00000000 0000F00D
0 1 1 0 00005000 00000000 00000000 89AB7FFF 0 00005000 3 00000000 00007FFF
0 2 1 0 00006000 00000000 00000000 11223380 0 00006000 1 00000000 FFFFFF80
0 2 0 0 00006000 00000000 00000000 11223380 0 00006000 1 00000000 00000080
0 2 1 0 00006007 00000000 00000000 9A000000 0 00006007 8 00000000 FFFFFF9A
0 2 0 1 00006000 00000007 00000000 9A000000 0 00006007 8 00000000 0000009A
0 2 1 0 00006007 00000000 00000000 7F112233 0 00006007 8 00000000 0000007F
0 0 0 0 00007000 00000000 00000000 00000000 1 00007000 f 00000000 00000000
1 0 0 0 00007008 00000000 0BADCAFE 00000000 1 00007008 f 0BADCAFE 00000000
0 2 0 0 0000700F 00000000 00000000 FF000000 1 0000700F 8 00000000 000000FF
1 1 0 0 00007010 00000000 0000BEEF 00000000 1 00007010 3 BEEFBEEF 00000000
0 0 0 0 00008000 00000000 00000000 55AA55AA 0 00008000 f 00000000 55AA55AA
0 1 1 1 00008000 00000010 00000000 00008001 0 00008010 3 00000000 FFFF8001
1 2 0 1 00008000 00000018 000000C3 00000000 0 00008018 1 C3C3C3C3 00000000
0 2 1 0 00008018 00000000 00000000 000000C3 0 00008018 1 00000000 FFFFFFC3
0 0 0 0 00009000 00000000 00000000 A5A55A5A 0 00009000 f 00000000 A5A55A5A
1 0 0 1 00009000 00000020 0F0F0F0F 00000000 0 00009020 f 0F0F0F0F 00000000
0 1 0 1 00009000 00000020 00000000 00018000 0 00009020 3 00000000 00008000

// File: vlog.f
+incdir+.
riscv_lsu_pkg.sv
lsu_req_if.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_ctrl.sv
riscv_lsu_top.sv
tb_riscv_lsu.sv

// File: run_verilator.sh
#!/usr/bin/env bash
# build and run the load-store unit testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps \
  -f vlog.f --top-module tb_riscv_lsu \
  --Mdir obj_dir -o tb_riscv_lsu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_riscv_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "simulation did not pass, see $LOG"
exit 1
